// ==== rtl/pisa_pkg.sv ====
//------------------------------------------------
// PISA shared types
// Opcodes, ALU functions and control/status bundles
//------------------------------------------------
package pisa_pkg;

  // Decoded instruction kinds
  typedef enum logic [3:0] {
    op_addu,
    op_subu,
    op_and,
    op_or,
    op_slt,
    op_addiu,
    op_lw,
    op_beq,
    op_bne,
    op_j,
    op_mfc0,
    op_mtc0,
    op_nop
  } opcode_t;

  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_cp1} alu_fn_t;
  typedef enum logic [1:0] {pc_plus4, pc_br, pc_jmp} pc_sel_t;
  typedef enum logic [1:0] {op1_rf, op1_imm, op1_mngr} op1_sel_t;

  localparam logic [31:0] reset_vector = 32'h0000_1000;
  localparam logic [31:0] nop_inst     = 32'h0000_0000;

  // Control unit to datapath, grouped by stage
  typedef struct packed {
    pc_sel_t     pc_sel;
    logic        reg_en_f;
    logic        reg_en_d;
    logic        reg_en_x;
    logic        reg_en_m;
    logic        reg_en_w;
    logic        squash_d;
    op1_sel_t    op1_sel;
    alu_fn_t     alu_fn;
    logic        wb_sel;
    logic [4:0]  rf_waddr;
    logic        rf_wen;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] inst_d;
    logic        br_eq_x;
  } status_t;

endpackage

// ==== rtl/pisa_alu.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// PISA ALU
// Combinational arithmetic and logic unit
//------------------------------------------------
module pisa_alu (
  input  logic [31:0]       in0,
  input  logic [31:0]       in1,
  input  pisa_pkg::alu_fn_t fn,
  output logic [31:0]       out
);
  import pisa_pkg::*;

  always_comb begin
    case (fn)
      alu_add: out = in0 + in1;
      alu_sub: out = in0 - in1;
      alu_and: out = in0 & in1;
      alu_or:  out = in0 | in1;
      // Signed compare
      alu_slt: out = {31'd0, $signed(in0) < $signed(in1)};
      alu_cp1: out = in1;
      default: out = 32'd0;
    endcase
  end

  // Function select must stay inside the enum
  always_comb begin
    assert ($isunknown(fn) ||
            fn inside {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_cp1})
      else $error("pisa_alu: undefined function %0d", fn);
  end

endmodule

// ==== rtl/pisa_regfile.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// PISA register file
// 32 x 32, two read ports, one write port
//------------------------------------------------
module pisa_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  // Register zero is never written
  always_ff @(posedge clk) begin
    if (wen && !rst && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through so a W-stage result reaches D in the same cycle
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return 32'd0;
    end else if (wen && addr == waddr) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata0 = read_port(raddr0);
    rdata1 = read_port(raddr1);
  end

endmodule

// ==== rtl/pisa_dpath.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// PISA five-stage datapath
// PC select, operand muxes, branch compare, writeback
//------------------------------------------------
module pisa_dpath (
  input  logic              clk,
  input  logic              rst,
  input  pisa_pkg::ctrl_t   ctrl,
  output pisa_pkg::status_t status,
  output logic [31:0]       imem_addr,
  input  logic [31:0]       imem_data,
  output logic [31:0]       dmem_addr,
  input  logic [31:0]       dmem_data,
  input  logic [31:0]       from_mngr_data,
  output logic [31:0]       to_mngr_data
);
  import pisa_pkg::*;

  logic [31:0] pc_plus4_f;
  logic [31:0] pc_next_f;
  logic [31:0] pc_plus4_d;
  logic [31:0] inst_d;
  logic [31:0] imm_sext_d;
  logic [31:0] rf_rdata0_d;
  logic [31:0] rf_rdata1_d;
  logic [31:0] op1_d;
  logic [31:0] br_target_d;
  logic [31:0] j_target_d;
  logic [31:0] op0_x;
  logic [31:0] op1_x;
  logic [31:0] br_target_x;
  logic [31:0] alu_result_x;
  logic [31:0] ex_result_m;
  logic [31:0] wb_result_m;
  logic [31:0] wb_result_w;

  //------------------------------------------------
  // F stage
  //------------------------------------------------
  always_comb begin
    case (ctrl.pc_sel)
      pc_br:   pc_next_f = br_target_x;
      pc_jmp:  pc_next_f = j_target_d;
      default: pc_next_f = pc_plus4_f;
    endcase
  end

  // Holds reset_vector until the first fetch advances
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_plus4_f <= reset_vector;
    end else if (ctrl.reg_en_f) begin
      pc_plus4_f <= pc_next_f + 32'd4;
    end
  end

  assign imem_addr = pc_next_f;

  //------------------------------------------------
  // D stage
  //------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || ctrl.squash_d) begin
      inst_d <= nop_inst;
    end else if (ctrl.reg_en_d) begin
      inst_d <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // rs on port 0, rt on port 1
  pisa_regfile rf_inst (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (inst_d[25:21]),
    .raddr1 (inst_d[20:16]),
    .rdata0 (rf_rdata0_d),
    .rdata1 (rf_rdata1_d),
    .wen    (ctrl.rf_wen),
    .waddr  (ctrl.rf_waddr),
    .wdata  (wb_result_w)
  );

  assign imm_sext_d = {{16{inst_d[15]}}, inst_d[15:0]};

  always_comb begin
    case (ctrl.op1_sel)
      op1_imm:  op1_d = imm_sext_d;
      op1_mngr: op1_d = from_mngr_data;
      default:  op1_d = rf_rdata1_d;
    endcase
  end

  // Redirect fetches are squashed before F steps on by 4
  // Both targets therefore point one word before the real one
  assign br_target_d = pc_plus4_d + {imm_sext_d[29:0], 2'b00};
  assign j_target_d  = {pc_plus4_d[31:28], inst_d[25:0], 2'b00} - 32'd4;

  //------------------------------------------------
  // X stage
  //------------------------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.reg_en_x) begin
      op0_x       <= rf_rdata0_d;
      op1_x       <= op1_d;
      br_target_x <= br_target_d;
    end
  end

  pisa_alu alu_inst (
    .in0 (op0_x),
    .in1 (op1_x),
    .fn  (ctrl.alu_fn),
    .out (alu_result_x)
  );

  assign dmem_addr = alu_result_x;

  //------------------------------------------------
  // M and W stages
  //------------------------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.reg_en_m) begin
      ex_result_m <= alu_result_x;
    end
  end

  // Load data arrives while the lw sits in M
  assign wb_result_m = ctrl.wb_sel ? dmem_data : ex_result_m;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_w) begin
      wb_result_w <= wb_result_m;
    end
  end

  assign to_mngr_data   = wb_result_w;
  assign status.inst_d  = inst_d;
  assign status.br_eq_x = (op0_x == op1_x);

endmodule

// ==== rtl/pisa_ctrl.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// PISA pipeline control
// Decode, stall/squash and per-stage control signals
//------------------------------------------------
module pisa_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  pisa_pkg::status_t status,
  output pisa_pkg::ctrl_t   ctrl,
  output logic              from_mngr_take,
  output logic              to_mngr_val
);
  import pisa_pkg::*;

  // What travels with an instruction past D
  typedef struct packed {
    logic       valid;
    opcode_t    op;
    logic [4:0] dest;
    logic       wen;
  } stage_t;

  logic [31:0] inst;
  logic        valid_d;
  opcode_t     op_d;
  logic        rs_en_d;
  logic        rt_en_d;
  logic        writes_d;
  logic [4:0]  dest_d;
  logic        stall_d;
  logic        jump_d;
  logic        br_taken_x;
  stage_t      x_q;
  stage_t      m_q;
  stage_t      w_q;

  assign inst = status.inst_d;

  // Decode on opcode, then funct or rs for the special groups
  always_comb begin
    op_d = op_nop;
    case (inst[31:26])
      6'b000000: begin
        case (inst[5:0])
          6'b100001: op_d = op_addu;
          6'b100011: op_d = op_subu;
          6'b100100: op_d = op_and;
          6'b100101: op_d = op_or;
          6'b101010: op_d = op_slt;
          default:   op_d = op_nop;
        endcase
      end
      6'b001001: op_d = op_addiu;
      6'b100011: op_d = op_lw;
      6'b000100: op_d = op_beq;
      6'b000101: op_d = op_bne;
      6'b000010: op_d = op_j;
      6'b010000: begin
        if (inst[25:21] == 5'b00000) begin
          op_d = op_mfc0;
        end else if (inst[25:21] == 5'b00100) begin
          op_d = op_mtc0;
        end
      end
      default:   op_d = op_nop;
    endcase
  end

  // Register usage per instruction
  always_comb begin
    rs_en_d  = 1'b0;
    rt_en_d  = 1'b0;
    writes_d = 1'b0;
    dest_d   = inst[20:16];
    case (op_d)
      op_addu, op_subu, op_and, op_or, op_slt: begin
        rs_en_d  = 1'b1;
        rt_en_d  = 1'b1;
        writes_d = 1'b1;
        dest_d   = inst[15:11];
      end
      op_addiu, op_lw: begin
        rs_en_d  = 1'b1;
        writes_d = 1'b1;
      end
      op_beq, op_bne: begin
        rs_en_d = 1'b1;
        rt_en_d = 1'b1;
      end
      op_mfc0: writes_d = 1'b1;
      op_mtc0: rt_en_d = 1'b1;
      default: ;
    endcase
  end

  //------------------------------------------------
  // Hazards
  //------------------------------------------------
  // W needs no check, the register file writes through
  function automatic logic hits(input stage_t s, input logic [4:0] src);
    return s.valid && s.wen && s.dest == src;
  endfunction

  assign stall_d = valid_d &&
                   ((rs_en_d && (hits(x_q, inst[25:21]) || hits(m_q, inst[25:21]))) ||
                    (rt_en_d && (hits(x_q, inst[20:16]) || hits(m_q, inst[20:16]))));
  assign jump_d  = valid_d && op_d == op_j;
  assign br_taken_x = x_q.valid && ((x_q.op == op_beq && status.br_eq_x) ||
                                    (x_q.op == op_bne && !status.br_eq_x));

  always_ff @(posedge clk) begin
    if (rst || ctrl.squash_d) begin
      valid_d <= 1'b0;
    end else if (ctrl.reg_en_d) begin
      valid_d <= 1'b1;
    end
  end

  // Bubble into X on a stall or when D is killed by a branch
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      m_q <= '0;
      w_q <= '0;
    end else begin
      x_q <= '{valid: valid_d && !stall_d && !br_taken_x, op: op_d,
               dest: dest_d, wen: writes_d && dest_d != 5'd0};
      m_q <= x_q;
      w_q <= m_q;
    end
  end

  //------------------------------------------------
  // Control outputs
  //------------------------------------------------
  always_comb begin
    ctrl.pc_sel   = br_taken_x ? pc_br : (jump_d ? pc_jmp : pc_plus4);
    ctrl.reg_en_f = !stall_d || br_taken_x;
    ctrl.reg_en_d = !stall_d;
    ctrl.reg_en_x = 1'b1;
    ctrl.reg_en_m = 1'b1;
    ctrl.reg_en_w = 1'b1;
    ctrl.squash_d = br_taken_x || jump_d;
    case (op_d)
      op_addiu, op_lw: ctrl.op1_sel = op1_imm;
      op_mfc0:         ctrl.op1_sel = op1_mngr;
      default:         ctrl.op1_sel = op1_rf;
    endcase
    case (x_q.op)
      op_subu, op_beq, op_bne: ctrl.alu_fn = alu_sub;
      op_and:                  ctrl.alu_fn = alu_and;
      op_or:                   ctrl.alu_fn = alu_or;
      op_slt:                  ctrl.alu_fn = alu_slt;
      op_mfc0, op_mtc0:        ctrl.alu_fn = alu_cp1;
      default:                 ctrl.alu_fn = alu_add;
    endcase
    ctrl.wb_sel   = (m_q.op == op_lw);
    ctrl.rf_waddr = w_q.dest;
    ctrl.rf_wen   = w_q.valid && w_q.wen;
  end

  assign from_mngr_take = valid_d && op_d == op_mfc0 && !stall_d && !br_taken_x;
  assign to_mngr_val    = w_q.valid && w_q.op == op_mtc0;

  // Redirect to a branch target only from a branch that left D last cycle
  assert property (@(posedge clk) disable iff (rst)
    ctrl.pc_sel == pc_br |->
      $past(valid_d && !stall_d && !br_taken_x && (op_d == op_beq || op_d == op_bne)));

  assert property (@(posedge clk) rst |=> !to_mngr_val);

endmodule

// ==== rtl/pisa_proc.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// PISA pipelined processor top
// Joins control unit and datapath
//------------------------------------------------
module pisa_proc (
  input  logic        clk,
  input  logic        rst,

  // Instruction memory
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,

  // Data memory
  output logic [31:0] dmem_addr,
  input  logic [31:0] dmem_data,

  // Manager ports
  input  logic [31:0] from_mngr_data,
  output logic        from_mngr_take,
  output logic [31:0] to_mngr_data,
  output logic        to_mngr_val
);
  import pisa_pkg::*;

  ctrl_t   ctrl;
  status_t status;

  pisa_ctrl ctrl_inst (
    .clk            (clk),
    .rst            (rst),
    .status         (status),
    .ctrl           (ctrl),
    .from_mngr_take (from_mngr_take),
    .to_mngr_val    (to_mngr_val)
  );

  pisa_dpath dpath_inst (
    .clk            (clk),
    .rst            (rst),
    .ctrl           (ctrl),
    .status         (status),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_data      (dmem_data),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr_data)
  );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// Testbench clock source, 100 ns period
//------------------------------------------------
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

// ==== tests/tb_pisa_proc.sv ====
`timescale 1ns/1ns
//------------------------------------------------
// PISA processor testbench
// Random programs run against an ISA-level model
//------------------------------------------------
module tb_pisa_proc;
  import pisa_pkg::*;

  localparam int prog_len = 96;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_data;
  logic [31:0] from_mngr_data;
  logic        from_mngr_take;
  logic [31:0] to_mngr_data;
  logic        to_mngr_val;

  logic [31:0] seed = 32'd9597;
  logic [31:0] dmem_salt;
  logic [31:0] dmem_addr_q;
  logic [31:0] prog [prog_len];
  opcode_t     intent [prog_len];
  logic [31:0] mngr_vals [256];
  logic [31:0] exp_out [$];
  int          exp_takes;
  int          mngr_idx;
  int          take_count;
  int          out_count;
  int          cycles_run;
  logic        take_pending;

  tb_clock clock_inst (.clk(clk));

  pisa_proc pisa_proc_inst (
    .clk            (clk),
    .rst            (rst),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_data      (dmem_data),
    .from_mngr_data (from_mngr_data),
    .from_mngr_take (from_mngr_take),
    .to_mngr_data   (to_mngr_data),
    .to_mngr_val    (to_mngr_val)
  );

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_op(input string name, input opcode_t exp, input opcode_t act);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH %s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  // LCG, numerical recipes constants
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Data memory contents are a hash of the full address
  function automatic logic [31:0] dmem_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ dmem_salt;
  endfunction

  function automatic logic [31:0] imem_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - reset_vector) >> 2;
    if (addr < reset_vector || idx >= prog_len || addr[1:0] != 2'b00) begin
      return nop_inst;
    end
    return prog[idx];
  endfunction

  // Independent decoder used by the model
  function automatic opcode_t decode(input logic [31:0] w);
    case (w[31:26])
      6'h00: begin
        case (w[5:0])
          6'h21:   return op_addu;
          6'h23:   return op_subu;
          6'h24:   return op_and;
          6'h25:   return op_or;
          6'h2a:   return op_slt;
          default: return op_nop;
        endcase
      end
      6'h09:   return op_addiu;
      6'h23:   return op_lw;
      6'h04:   return op_beq;
      6'h05:   return op_bne;
      6'h02:   return op_j;
      6'h10:   return (w[25:21] == 5'd0) ? op_mfc0 : ((w[25:21] == 5'd4) ? op_mtc0 : op_nop);
      default: return op_nop;
    endcase
  endfunction

  task automatic emit(input int at, input opcode_t op, input logic [4:0] rs,
                      input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] imm);
    intent[at] = op;
    case (op)
      op_addu:  prog[at] = {6'h00, rs, rt, rd, 5'd0, 6'h21};
      op_subu:  prog[at] = {6'h00, rs, rt, rd, 5'd0, 6'h23};
      op_and:   prog[at] = {6'h00, rs, rt, rd, 5'd0, 6'h24};
      op_or:    prog[at] = {6'h00, rs, rt, rd, 5'd0, 6'h25};
      op_slt:   prog[at] = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
      op_addiu: prog[at] = {6'h09, rs, rt, imm};
      op_lw:    prog[at] = {6'h23, rs, rt, imm};
      op_beq:   prog[at] = {6'h04, rs, rt, imm};
      op_bne:   prog[at] = {6'h05, rs, rt, imm};
      op_j:     prog[at] = {6'h02, 10'd0, imm};
      op_mfc0:  prog[at] = {6'h10, 5'd0, rt, 16'd0};
      op_mtc0:  prog[at] = {6'h10, 5'd4, rt, 16'd0};
      default:  prog[at] = nop_inst;
    endcase
  endtask

  //------------------------------------------------
  // Program generator, forward control flow only
  //------------------------------------------------
  task automatic build_program();
    int i;
    int k;
    logic [31:0] r;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    for (int n = 0; n < prog_len; n++) begin
      emit(n, op_nop, 5'd0, 5'd0, 5'd0, 16'd0);
    end
    for (int n = 1; n < 8; n++) begin
      emit(n - 1, op_mfc0, 5'd0, 5'(n), 5'd0, 16'd0);
    end
    i = 7;
    while (i < prog_len - 12) begin
      r  = next_rand();
      rs = 5'(1 + r[10:8] % 7);
      rt = r[20] ? rs : 5'(1 + r[14:12] % 7);
      rd = 5'(1 + r[18:16] % 7);
      k  = int'(r[7:0] % 16);
      case (k)
        0, 1, 2, 3, 4: emit(i, opcode_t'(4'(k)), rs, rt, rd, 16'd0);
        5: emit(i, op_addiu, rs, rt, 5'd0, r[31:16]);
        6: begin
          // Load then use at once
          emit(i, op_lw, rs, rt, 5'd0, r[31:16]);
          i = i + 1;
          emit(i, op_mtc0, 5'd0, rt, 5'd0, 16'd0);
        end
        7: emit(i, op_beq, rs, rt, 5'd0, 16'(1 + r[25:24]));
        8: emit(i, op_bne, rs, rt, 5'd0, 16'(1 + r[25:24]));
        9: begin
          // Skipped slot, then an mtc0 at the target
          emit(i, op_j, 5'd0, 5'd0, 5'd0, 16'(1024 + i + 2));
          emit(i + 1, op_mtc0, 5'd0, rt, 5'd0, 16'd0);
          emit(i + 2, op_mtc0, 5'd0, rs, 5'd0, 16'd0);
          i = i + 2;
        end
        10: emit(i, op_mfc0, 5'd0, rt, 5'd0, 16'd0);
        default: emit(i, op_mtc0, 5'd0, rt, 5'd0, 16'd0);
      endcase
      i = i + 1;
    end
    for (int n = 1; n < 8; n++) begin
      emit(i + n - 1, op_mtc0, 5'd0, 5'(n), 5'd0, 16'd0);
    end
  endtask

  //------------------------------------------------
  // ISA reference model, no timing
  //------------------------------------------------
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    int mi;
    for (int n = 0; n < 32; n++) begin
      regs[n] = 32'd0;
    end
    pc = reset_vector;
    mi = 0;
    while (pc >= reset_vector && pc < reset_vector + 4 * prog_len) begin
      w    = imem_word(pc);
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      sext = {{16{w[15]}}, w[15:0]};
      pc   = pc + 32'd4;
      case (decode(w))
        op_addu:  regs[w[15:11]] = a + b;
        op_subu:  regs[w[15:11]] = a - b;
        op_and:   regs[w[15:11]] = a & b;
        op_or:    regs[w[15:11]] = a | b;
        op_slt:   regs[w[15:11]] = {31'd0, $signed(a) < $signed(b)};
        op_addiu: regs[w[20:16]] = a + sext;
        op_lw:    regs[w[20:16]] = dmem_word(a + sext);
        op_beq:   pc = (a == b) ? pc + {sext[29:0], 2'b00} : pc;
        op_bne:   pc = (a != b) ? pc + {sext[29:0], 2'b00} : pc;
        op_j:     pc = {pc[31:28], w[25:0], 2'b00};
        op_mfc0: begin
          regs[w[20:16]] = mngr_vals[mi];
          mi = mi + 1;
        end
        op_mtc0:  exp_out.push_back(b);
        default: ;
      endcase
      regs[0] = 32'd0;
    end
    exp_takes = mi;
  endtask

  // Memories and manager, driven on the falling edge
  always @(negedge clk) begin
    imem_data   <= imem_word(imem_addr);
    dmem_data   <= dmem_word(dmem_addr_q);
    dmem_addr_q = dmem_addr;
    if (take_pending) begin
      mngr_idx = mngr_idx + 1;
      from_mngr_data <= mngr_vals[mngr_idx];
    end
    take_pending = (from_mngr_take === 1'b1);
    if (take_pending) begin
      take_count = take_count + 1;
    end
    if (!rst) begin
      cycles_run = cycles_run + 1;
    end
    if (to_mngr_val === 1'b1) begin
      if (rst || cycles_run < 4) begin
        fail_now("to_mngr_val pulsed before any mtc0 could reach W");
      end
      if (out_count >= exp_out.size()) begin
        fail_now("to_mngr_val pulsed after the model ran out of results");
      end
      check_word($sformatf("to_mngr %0d", out_count), exp_out[out_count], to_mngr_data);
      out_count = out_count + 1;
    end
  end

  initial begin
    int waited;
    rst            = 1'b1;
    imem_data      = 32'd0;
    dmem_data      = 32'd0;
    from_mngr_data = 32'd0;
    dmem_addr_q    = 32'd0;
    take_pending   = 1'b0;
    mngr_idx       = 0;
    take_count     = 0;
    out_count      = 0;
    cycles_run     = 0;
    dmem_salt      = next_rand();
    for (int n = 0; n < 256; n++) begin
      mngr_vals[n] = next_rand();
    end
    build_program();
    for (int n = 0; n < prog_len; n++) begin
      check_op($sformatf("encode %0d", n), intent[n], decode(prog[n]));
    end
    run_model();
    from_mngr_data = mngr_vals[0];

    repeat (5) @(posedge clk);
    @(negedge clk);
    check_word("reset fetch", reset_vector, imem_addr);
    rst = 1'b0;

    waited = 0;
    while (out_count < exp_out.size()) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > 5000) begin
        fail_now("timed out waiting for to_mngr results");
      end
    end
    // Drain so that stray pulses show up
    waited = 0;
    while (waited < 40) begin
      @(negedge clk);
      waited = waited + 1;
    end
    check_word("from_mngr_take count", 32'(exp_takes), 32'(take_count));
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/pisa_pkg.sv
rtl/pisa_alu.sv
rtl/pisa_regfile.sv
rtl/pisa_dpath.sv
rtl/pisa_ctrl.sv
rtl/pisa_proc.sv
tests/tb_clock.sv
tests/tb_pisa_proc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PISA processor testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module tb_pisa_proc -o sim_pisa
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_pisa > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
else
  exit 1
fi
